//--- hw/window_fetch_pkg.sv
package window_fetch_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    localparam int PIXEL_WIDTH       = 8;
    localparam int LANES             = 9;
    localparam int NUM_BANKS         = 9;
    localparam int WINDOW_DIM        = 3;
    localparam int BANK_ADDR_WIDTH   = 19;
    localparam int COORD_WIDTH       = 8;
    localparam int CHANNEL_WIDTH     = 11;

    // Cycles from bank_read_en to data at the bank outputs
    localparam int BANK_READ_LATENCY = 1;

    // Reciprocal multiply for x / 3, exact over the full coordinate range
    localparam int DIV3_SHIFT        = COORD_WIDTH + 1;
    localparam int DIV3_MAGIC        = ((2 ** DIV3_SHIFT) + 2) / 3;

    ////////////////////
    // Types
    ////////////////////

    // Nine channel lanes per bank word
    typedef logic [LANES-1:0][PIXEL_WIDTH-1:0] bank_word_t;

    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] base_addr;
        logic [COORD_WIDTH-1:0]     h;
        logic [COORD_WIDTH-1:0]     v;
        logic [CHANNEL_WIDTH-1:0]   channel_num;
        logic [COORD_WIDTH-1:0]     fmap_size;
        logic [CHANNEL_WIDTH-1:0]   fmap_channels;
    } fetch_req_t;

    // Centre coordinate mod 3, only 0..2 are legal
    typedef struct packed {
        logic [1:0] col_phase;
        logic [1:0] row_phase;
    } window_phase_t;

    typedef struct packed {
        logic [COORD_WIDTH-1:0]     h_block;
        logic [COORD_WIDTH-1:0]     v_block;
        logic [COORD_WIDTH-1:0]     row_blocks;
        window_phase_t              phase;
        logic [BANK_ADDR_WIDTH-1:0] base_addr;
        logic [CHANNEL_WIDTH-1:0]   channel_num;
        logic [CHANNEL_WIDTH-1:0]   fmap_channels;
    } block_pos_t;

    typedef logic [NUM_BANKS-1:0][BANK_ADDR_WIDTH-1:0] bank_addr_vec_t;

    // Indexed by bank on the memory side, by window position on the output
    typedef bank_word_t [NUM_BANKS-1:0] bank_word_vec_t;

endpackage

//--- hw/div_by3.sv
`timescale 1ns/10ps

module div_by3 (
    input  logic [window_fetch_pkg::COORD_WIDTH-1:0] value,
    output logic [window_fetch_pkg::COORD_WIDTH-1:0] quotient,
    output logic [1:0]                               remainder
);
    import window_fetch_pkg::*;

    logic [2*COORD_WIDTH-1:0] product;
    logic [COORD_WIDTH+1:0]   triple;
    logic [COORD_WIDTH+1:0]   rebuilt;

    // Multiply by 2^(W+1)/3 rounded up, then drop the fraction
    assign product  = (2*COORD_WIDTH)'(value) * (2*COORD_WIDTH)'(DIV3_MAGIC);
    assign quotient = COORD_WIDTH'(product >> DIV3_SHIFT);

    assign triple    = (COORD_WIDTH+2)'(quotient) * (COORD_WIDTH+2)'(3);
    assign remainder = 2'((COORD_WIDTH+2)'(value) - triple);

    assign rebuilt = triple + (COORD_WIDTH+2)'(remainder);

    always_comb begin
        if (!$isunknown(value)) begin
            assert final (rebuilt == (COORD_WIDTH+2)'(value) && remainder != 2'd3)
                else $error("div_by3: %0d != 3*%0d + %0d", value, quotient, remainder);
        end
    end

endmodule

//--- hw/fetch_request_stage.sv
`timescale 1ns/10ps

module fetch_request_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_strobe,
    input  window_fetch_pkg::fetch_req_t req,
    output window_fetch_pkg::block_pos_t pos,
    output logic                         pos_valid
);
    import window_fetch_pkg::*;

    logic [COORD_WIDTH-1:0] h_quot;
    logic [1:0]             h_rem;
    logic [COORD_WIDTH-1:0] v_quot;
    logic [1:0]             v_rem;
    logic [COORD_WIDTH-1:0] size_quot;
    logic [1:0]             size_rem;
    logic [COORD_WIDTH-1:0] row_blocks;

    div_by3 h_div_i (
        .value     (req.h),
        .quotient  (h_quot),
        .remainder (h_rem)
    );

    div_by3 v_div_i (
        .value     (req.v),
        .quotient  (v_quot),
        .remainder (v_rem)
    );

    div_by3 size_div_i (
        .value     (req.fmap_size),
        .quotient  (size_quot),
        .remainder (size_rem)
    );

    // A partial last block still takes a whole block slot
    assign row_blocks = size_quot + COORD_WIDTH'(size_rem != 2'd0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pos_valid <= 1'b0;
        end else begin
            pos_valid <= fetch_strobe;
        end
    end

    ////////////////////
    // Request capture
    ////////////////////

    always_ff @(posedge clk) begin
        if (fetch_strobe) begin
            pos.h_block         <= h_quot;
            pos.v_block         <= v_quot;
            pos.row_blocks      <= row_blocks;
            pos.phase.col_phase <= h_rem;
            pos.phase.row_phase <= v_rem;
            pos.base_addr       <= req.base_addr;
            pos.channel_num     <= req.channel_num;
            pos.fmap_channels   <= req.fmap_channels;
        end
    end

endmodule

//--- hw/bank_addr_gen.sv
`timescale 1ns/10ps

module bank_addr_gen (
    input  logic                             clk,
    input  logic                             rst,
    input  window_fetch_pkg::block_pos_t     pos,
    input  logic                             pos_valid,
    output window_fetch_pkg::bank_addr_vec_t bank_addr,
    output logic                             bank_read_en,
    output window_fetch_pkg::window_phase_t  rd_phase
);
    import window_fetch_pkg::*;

    logic [BANK_ADDR_WIDTH-1:0] row_stride;
    bank_addr_vec_t             next_addr;

    // Neighbour block for a bank, same rule on both axes
    function automatic logic [COORD_WIDTH-1:0] pick_block(
        input logic [COORD_WIDTH-1:0] block,
        input logic [1:0]             bank_phase,
        input logic [1:0]             centre_phase
    );
        if (bank_phase == 2'd2 && centre_phase == 2'd0) begin
            return block - 1'b1;
        end else if (bank_phase == 2'd0 && centre_phase == 2'd2) begin
            return block + 1'b1;
        end
        return block;
    endfunction

    // Words per row of blocks
    assign row_stride = BANK_ADDR_WIDTH'(pos.row_blocks) * BANK_ADDR_WIDTH'(pos.fmap_channels);

    ////////////////////
    // Address terms
    ////////////////////

    always_comb begin : addr_calc
        logic [COORD_WIDTH-1:0] h_sel;
        logic [COORD_WIDTH-1:0] v_sel;
        for (int b = 0; b < NUM_BANKS; b++) begin
            h_sel = pick_block(pos.h_block, 2'(b % WINDOW_DIM), pos.phase.col_phase);
            v_sel = pick_block(pos.v_block, 2'(b / WINDOW_DIM), pos.phase.row_phase);
            next_addr[b] = pos.base_addr
                         + BANK_ADDR_WIDTH'(h_sel) * BANK_ADDR_WIDTH'(pos.fmap_channels)
                         + BANK_ADDR_WIDTH'(v_sel) * row_stride
                         + BANK_ADDR_WIDTH'(pos.channel_num);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            bank_read_en <= 1'b0;
        end else begin
            bank_read_en <= pos_valid;
        end
    end

    // Addresses and phase move together with the enable
    always_ff @(posedge clk) begin
        if (pos_valid) begin
            bank_addr <= next_addr;
            rd_phase  <= pos.phase;
        end
    end

    // Phases come from the divider remainders two stages back
    read_phase_legal: assert property (
        @(posedge clk) disable iff (!rst)
        bank_read_en |-> (rd_phase.col_phase != 2'd3 && rd_phase.row_phase != 2'd3)
    ) else $error("bank_addr_gen: illegal phase %b", rd_phase);

endmodule

//--- hw/window_assembler.sv
`timescale 1ns/10ps

module window_assembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             bank_read_en,
    input  window_fetch_pkg::window_phase_t  rd_phase,
    input  window_fetch_pkg::bank_word_vec_t bank_data,
    output window_fetch_pkg::bank_word_vec_t window,
    output logic                             window_valid
);
    import window_fetch_pkg::*;

    logic [BANK_READ_LATENCY-1:0] en_pipe;
    window_phase_t                phase_pipe [BANK_READ_LATENCY];
    window_phase_t                win_phase;

    function automatic logic [1:0] wrap3(input logic [2:0] sum);
        if (sum >= 3'd6) begin
            return 2'(sum - 3'd6);
        end else if (sum >= 3'd3) begin
            return 2'(sum - 3'd3);
        end
        return 2'(sum);
    endfunction

    ////////////////////
    // Latency match
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            en_pipe <= '0;
        end else begin
            en_pipe[0] <= bank_read_en;
            for (int i = 1; i < BANK_READ_LATENCY; i++) begin
                en_pipe[i] <= en_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        phase_pipe[0] <= rd_phase;
        for (int i = 1; i < BANK_READ_LATENCY; i++) begin
            phase_pipe[i] <= phase_pipe[i-1];
        end
    end

    assign window_valid = en_pipe[BANK_READ_LATENCY-1];
    assign win_phase    = phase_pipe[BANK_READ_LATENCY-1];

    // Position dx holds column phase (col_phase - 1 + dx) mod 3, same for rows
    always_comb begin : route
        logic [1:0] col_sel;
        logic [1:0] row_sel;
        for (int dy = 0; dy < WINDOW_DIM; dy++) begin
            for (int dx = 0; dx < WINDOW_DIM; dx++) begin
                col_sel = wrap3(3'(win_phase.col_phase) + 3'(dx) + 3'd2);
                row_sel = wrap3(3'(win_phase.row_phase) + 3'(dy) + 3'd2);
                if (window_valid) begin
                    window[WINDOW_DIM*dy + dx] = bank_data[WINDOW_DIM*row_sel + col_sel];
                end else begin
                    window[WINDOW_DIM*dy + dx] = '0;
                end
            end
        end
    end

    window_follows_read: assert property (
        @(posedge clk) disable iff (!rst)
        window_valid == $past(bank_read_en, BANK_READ_LATENCY)
    ) else $error("window_assembler: window_valid out of step with bank_read_en");

endmodule

//--- hw/window_fetch.sv
`timescale 1ns/10ps

module window_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_strobe,
    input  window_fetch_pkg::fetch_req_t     req,
    input  window_fetch_pkg::bank_word_vec_t bank_data,
    output window_fetch_pkg::bank_addr_vec_t bank_addr,
    output logic                             bank_read_en,
    output window_fetch_pkg::bank_word_vec_t window,
    output logic                             window_valid
);
    import window_fetch_pkg::*;

    block_pos_t    pos;
    logic          pos_valid;
    window_phase_t rd_phase;

    ////////////////////
    // Pipeline
    ////////////////////

    fetch_request_stage request_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_strobe (fetch_strobe),
        .req          (req),
        .pos          (pos),
        .pos_valid    (pos_valid)
    );

    bank_addr_gen addr_gen_i (
        .clk          (clk),
        .rst          (rst),
        .pos          (pos),
        .pos_valid    (pos_valid),
        .bank_addr    (bank_addr),
        .bank_read_en (bank_read_en),
        .rd_phase     (rd_phase)
    );

    // Banks sit outside, data returns on bank_data
    window_assembler assembler_i (
        .clk          (clk),
        .rst          (rst),
        .bank_read_en (bank_read_en),
        .rd_phase     (rd_phase),
        .bank_data    (bank_data),
        .window       (window),
        .window_valid (window_valid)
    );

endmodule

//--- tests/bank_model.sv
`timescale 1ns/10ps

module bank_model (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             read_en,
    input  window_fetch_pkg::bank_addr_vec_t addr,
    output window_fetch_pkg::bank_word_vec_t data
);
    import window_fetch_pkg::*;

    bank_word_vec_t data_pipe [BANK_READ_LATENCY];

    // Lane l of bank b at address a holds 7a + 13b + l
    function automatic bank_word_t word_at(
        input int                         bank,
        input logic [BANK_ADDR_WIDTH-1:0] a
    );
        bank_word_t w;
        for (int l = 0; l < LANES; l++) begin
            w[l] = PIXEL_WIDTH'(7 * int'(a) + 13 * bank + l);
        end
        return w;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < BANK_READ_LATENCY; i++) begin
                data_pipe[i] <= '0;
            end
        end else begin
            if (read_en) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    data_pipe[0][b] <= word_at(b, addr[b]);
                end
            end
            for (int i = 1; i < BANK_READ_LATENCY; i++) begin
                data_pipe[i] <= data_pipe[i-1];
            end
        end
    end

    assign data = data_pipe[BANK_READ_LATENCY-1];

endmodule

//--- tests/window_fetch_tb.sv
`timescale 1ns/10ps

module window_fetch_tb;
    import window_fetch_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int BURST_LEN    = 24;
    // 1 + 1 + 9 + 9 + burst
    localparam int NUM_REQUESTS = 20 + BURST_LEN;

    logic           clk;
    logic           rst;
    logic           fetch_strobe;
    fetch_req_t     req;
    bank_word_vec_t bank_data;
    bank_addr_vec_t bank_addr;
    logic           bank_read_en;
    bank_word_vec_t window;
    logic           window_valid;

    bank_word_vec_t exp_q [$];
    int             value_errors;
    int             other_errors;

    window_fetch dut_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_strobe (fetch_strobe),
        .req          (req),
        .bank_data    (bank_data),
        .bank_addr    (bank_addr),
        .bank_read_en (bank_read_en),
        .window       (window),
        .window_valid (window_valid)
    );

    bank_model banks_i (
        .clk     (clk),
        .rst     (rst),
        .read_en (bank_read_en),
        .addr    (bank_addr),
        .data    (bank_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Reference
    ////////////////////

    function automatic fetch_req_t build_request(input int base, input int h, input int v,
                                                 input int ch, input int size, input int chans);
        fetch_req_t r;
        r.base_addr     = BANK_ADDR_WIDTH'(base);
        r.h             = COORD_WIDTH'(h);
        r.v             = COORD_WIDTH'(v);
        r.channel_num   = CHANNEL_WIDTH'(ch);
        r.fmap_size     = COORD_WIDTH'(size);
        r.fmap_channels = CHANNEL_WIDTH'(chans);
        return r;
    endfunction

    // Word address of pixel (c, r) in its bank
    function automatic int pixel_addr(input fetch_req_t r, input int c, input int row);
        int row_blocks;
        row_blocks = (int'(r.fmap_size) + 2) / 3;
        return (int'(r.base_addr) + (c / 3) * int'(r.fmap_channels)
                + (row / 3) * row_blocks * int'(r.fmap_channels)
                + int'(r.channel_num)) & ((1 << BANK_ADDR_WIDTH) - 1);
    endfunction

    function automatic bank_word_vec_t expected_window(input fetch_req_t r);
        bank_word_vec_t w;
        int c;
        int row;
        int bank;
        int a;
        for (int dy = 0; dy < 3; dy++) begin
            for (int dx = 0; dx < 3; dx++) begin
                c    = int'(r.h) - 1 + dx;
                row  = int'(r.v) - 1 + dy;
                bank = 3 * (row % 3) + (c % 3);
                a    = pixel_addr(r, c, row);
                for (int l = 0; l < LANES; l++) begin
                    w[3*dy + dx][l] = 8'(7 * a + 13 * bank + l);
                end
            end
        end
        return w;
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t %s: expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic compare_window(input string name, input bank_word_vec_t expected,
                                  input bank_word_vec_t actual);
        for (int p = 0; p < NUM_BANKS; p++) begin
            if (actual[p] !== expected[p]) begin
                value_errors++;
                $display("[FAIL] %0t %s[%0d]: expected %h, got %h",
                         $time, name, p, expected[p], actual[p]);
                return;
            end
        end
    endtask

    task automatic compare_addr(input string name, input bank_addr_vec_t expected,
                                input bank_addr_vec_t actual);
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (actual[b] !== expected[b]) begin
                value_errors++;
                $display("[FAIL] %0t %s[%0d]: expected %h, got %h",
                         $time, name, b, expected[b], actual[b]);
            end
        end
    endtask

    // Every window goes through here, in request order
    always @(posedge clk) begin
        if (rst) begin
            if (window_valid) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("A window arrived at %0t with no request outstanding", $time);
                end else begin
                    compare_window("window", exp_q.pop_front(), window);
                end
            end else begin
                compare_window("window (idle)", '0, window);
            end
        end
    end

    ////////////////////
    // Tests
    ////////////////////

    // Returns on the falling edge after the strobe was sampled
    task automatic issue_request(input fetch_req_t r);
        @(negedge clk);
        fetch_strobe = 1'b1;
        req          = r;
        exp_q.push_back(expected_window(r));
        @(negedge clk);
        fetch_strobe = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic test_reset_idle();
        repeat (8) begin
            @(negedge clk);
            compare_bit("bank_read_en", 1'b0, bank_read_en);
            compare_bit("window_valid", 1'b0, window_valid);
        end
        issue_request(build_request(0, 4, 7, 2, 12, 9));
        // k counts cycles from the falling edge that raised the strobe
        for (int k = 2; k <= 5; k++) begin
            @(negedge clk);
            compare_bit("bank_read_en", k == 2, bank_read_en);
            compare_bit("window_valid", k == 3, window_valid);
        end
        wait_drain();
    endtask

    task automatic test_centre_phase();
        fetch_req_t     r;
        bank_addr_vec_t exp_addr;
        int             count;
        r = build_request(19'h00040, 4, 4, 5, 12, 9);
        for (int b = 0; b < NUM_BANKS; b++) begin
            exp_addr[b] = BANK_ADDR_WIDTH'(pixel_addr(r, 4, 4));
        end
        issue_request(r);
        count = 0;
        while (!bank_read_en && count < 8) begin
            @(negedge clk);
            count++;
        end
        if (!bank_read_en) begin
            other_errors++;
            $display("bank_read_en never rose for the phase (1,1) request");
        end else begin
            compare_addr("bank_addr", exp_addr, bank_addr);
        end
        wait_drain();
    endtask

    task automatic test_all_phases();
        for (int rp = 0; rp < 3; rp++) begin
            for (int cp = 0; cp < 3; cp++) begin
                issue_request(build_request(0, 6 + cp, 3 + rp, cp + rp, 12, 9));
            end
        end
        wait_drain();
    endtask

    task automatic test_partial_blocks();
        int hs [3] = '{8, 1, 5};
        int vs [3] = '{8, 5, 1};
        int chs [3] = '{0, 3, 8};
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                issue_request(build_request(19'h00123, hs[i], vs[i], chs[j], 10, 9));
            end
        end
        wait_drain();
    endtask

    // Strobe driven at falling edge k shows up as a window at falling edge k+3
    task automatic test_back_to_back();
        fetch_req_t r;
        for (int k = 0; k < BURST_LEN + 4; k++) begin
            @(negedge clk);
            compare_bit("window_valid", k >= 3 && k < BURST_LEN + 3, window_valid);
            if (k < BURST_LEN) begin
                r = build_request($urandom % 4096, 1 + $urandom % 13, 1 + $urandom % 13,
                                  $urandom % 16, 15, 16);
                fetch_strobe = 1'b1;
                req          = r;
                exp_q.push_back(expected_window(r));
            end else begin
                fetch_strobe = 1'b0;
            end
        end
        wait_drain();
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_REQUESTS * 10 + RESET_CYCLES));
        $display("Watchdog expired, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'habeb_9030));
        value_errors = 0;
        other_errors = 0;
        clk          = 1'b0;
        rst          = 1'b0;
        fetch_strobe = 1'b0;
        req          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_reset_idle();
        test_centre_phase();
        test_all_phases();
        test_partial_blocks();
        test_back_to_back();

        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected windows never arrived", exp_q.size());
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- window_fetch.f
hw/window_fetch_pkg.sv
hw/div_by3.sv
hw/fetch_request_stage.sv
hw/bank_addr_gen.sv
hw/window_assembler.sv
hw/window_fetch.sv
tests/bank_model.sv
tests/window_fetch_tb.sv
